// ==== Makefile ====
# Verilator build and run for the mixed width block RAM testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tb_mixed_width_bram
FILELIST  := verilog.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))
PASS_MSG  := PASS: all tests

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the run passes only if the pass line shows up in the output
run: $(SIM)
	@out="$$(./$(SIM) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== logic/bram_geom_pkg.sv ====
// storage geometry of the 16 Kb mixed width block ram
// port a sees halfwords, port b sees words, both over the same byte lanes
// all sizes are fixed here; other widths are not supported

package bram_geom_pkg;

	// a word is split into this many byte lanes
	localparam int lane_count = 4;

	// bits per lane
	localparam int byte_width = 8;

	// lanes that make up one port a halfword
	localparam int half_lanes = 2;

	// halfwords per word
	localparam int word_halves = lane_count / half_lanes;

	// port widths in bits
	localparam int half_width = half_lanes * byte_width;
	localparam int word_width = lane_count * byte_width;

	// 512 words of 32 bits gives 16 Kb
	localparam int word_depth = 512;

	// address widths, word index for port b and halfword index for port a
	localparam int word_addr_width = 9;
	localparam int half_addr_width = 10;

endpackage

// ==== logic/bram_port_pkg.sv ====
// data, enable and address types for both ram ports
// halfword address h maps to word h/2, the even address is the low half
// the union gives two views of one word and adds no logic

package bram_port_pkg;

	// one lane of storage
	typedef logic [bram_geom_pkg::byte_width-1:0] byte_t;

	// port a data
	typedef logic [bram_geom_pkg::half_width-1:0] half_t;

	// port b data
	typedef logic [bram_geom_pkg::word_width-1:0] word_t;

	// word index, shared by port b and the lane storage
	typedef logic [bram_geom_pkg::word_addr_width-1:0] word_addr_t;

	// port a halfword address
	typedef logic [bram_geom_pkg::half_addr_width-1:0] half_addr_t;

	// byte enables, one bit per lane
	typedef logic [bram_geom_pkg::half_lanes-1:0] half_we_t;
	typedef logic [bram_geom_pkg::lane_count-1:0] word_we_t;

	// one word seen as four bytes or as two halfwords
	// index 0 is the low lane or the low half
	typedef union packed {
		byte_t [bram_geom_pkg::lane_count-1:0] bytes;
		half_t [bram_geom_pkg::word_halves-1:0] halves;
	} word_lanes_u;

endpackage

// ==== logic/half_port_map.sv ====
// steers 16 bit port a requests onto lane pair 0-1 or 2-3
// the low address bit picks the pair, the rest is the word index
// one cycle read latency, no stall; one request per cycle at most

`timescale 1ns/1ps

module half_port_map (
	input  logic                       clk_a_in,
	input  logic                       rst,

	input  logic                       en_a,
	input  bram_port_pkg::half_we_t    we_a,
	input  bram_port_pkg::half_addr_t  addr_a,
	input  bram_port_pkg::half_t       wr_data_a,

	output bram_port_pkg::word_we_t    lane_en,
	output bram_port_pkg::word_we_t    lane_we,
	output bram_port_pkg::word_addr_t  lane_addr,
	output bram_port_pkg::word_lanes_u lane_wr,
	input  bram_port_pkg::word_lanes_u lane_rd,

	output bram_port_pkg::half_t       rd_data_a,
	output logic                       rd_valid_a
);

	logic half_sel;
	logic half_sel_q;
	logic valid_q;

	// even halfword address is the low half of the word
	assign half_sel = addr_a[0];
	assign lane_addr = addr_a[bram_geom_pkg::half_addr_width-1:1];

	// enable only the lane pair that holds the addressed halfword
	always_comb begin
		for (int i = 0; i < bram_geom_pkg::lane_count; i++) begin
			lane_en[i] = en_a && ((i / bram_geom_pkg::half_lanes) == int'(half_sel));
			lane_we[i] = lane_en[i] && we_a[i % bram_geom_pkg::half_lanes];
		end
	end

	// same data on both halves, the enables decide which one is used
	always_comb begin
		for (int h = 0; h < bram_geom_pkg::word_halves; h++) begin
			lane_wr.halves[h] = wr_data_a;
		end
	end

	// remember which half to return on the next cycle
	always_ff @(posedge clk_a_in) begin
		if (rst) begin
			half_sel_q <= 1'b0;
			valid_q <= 1'b0;
		end else begin
			valid_q <= en_a;
			if (en_a) begin
				half_sel_q <= half_sel;
			end
		end
	end

	assign rd_data_a = lane_rd.halves[half_sel_q];
	assign rd_valid_a = valid_q;

endmodule

// ==== logic/mixed_width_bram.sv ====
// 16 Kb dual port ram, port a 16 bit by 1024, port b 32 bit by 512
// both ports share clk_a_in; read data is registered with one cycle latency
// a same-byte write from both ports in one cycle stores port a's byte

`timescale 1ns/1ps

module mixed_width_bram (
	input  logic                      clk_a_in,
	input  logic                      rst,

	// port a, halfword wide
	input  logic                      en_a,
	input  bram_port_pkg::half_we_t   we_a,
	input  bram_port_pkg::half_addr_t addr_a,
	input  bram_port_pkg::half_t      wr_data_a,
	output bram_port_pkg::half_t      rd_data_a,
	output logic                      rd_valid_a,

	// port b, word wide
	input  logic                      en_b,
	input  bram_port_pkg::word_we_t   we_b,
	input  bram_port_pkg::word_addr_t addr_b,
	input  bram_port_pkg::word_t      wr_data_b,
	output bram_port_pkg::word_t      rd_data_b,
	output logic                      rd_valid_b
);

	// port a side, after the halfword map
	bram_port_pkg::word_we_t    lane_en;
	bram_port_pkg::word_we_t    lane_we;
	bram_port_pkg::word_addr_t  lane_addr;
	bram_port_pkg::word_lanes_u lane_wr;
	bram_port_pkg::word_lanes_u lane_rd;

	// port b split into lanes
	bram_port_pkg::word_lanes_u wr_b_lanes;
	bram_port_pkg::word_lanes_u rd_b_lanes;

	// one read byte per lane and port
	bram_port_pkg::byte_t rd_a_byte [bram_geom_pkg::lane_count];
	bram_port_pkg::byte_t rd_b_byte [bram_geom_pkg::lane_count];

	logic valid_b_q;

	half_port_map u_half_map (
		.clk_a_in   (clk_a_in),
		.rst        (rst),
		.en_a       (en_a),
		.we_a       (we_a),
		.addr_a     (addr_a),
		.wr_data_a  (wr_data_a),
		.lane_en    (lane_en),
		.lane_we    (lane_we),
		.lane_addr  (lane_addr),
		.lane_wr    (lane_wr),
		.lane_rd    (lane_rd),
		.rd_data_a  (rd_data_a),
		.rd_valid_a (rd_valid_a)
	);

	assign wr_b_lanes = wr_data_b;

	for (genvar i = 0; i < bram_geom_pkg::lane_count; i++) begin : g_lane
		ram_lane u_lane (
			.clk_a_in  (clk_a_in),
			.rst       (rst),
			.en_a      (lane_en[i]),
			.we_a      (lane_we[i]),
			.addr_a    (lane_addr),
			.wr_byte_a (lane_wr.bytes[i]),
			.rd_byte_a (rd_a_byte[i]),
			.en_b      (en_b),
			.we_b      (we_b[i]),
			.addr_b    (addr_b),
			.wr_byte_b (wr_b_lanes.bytes[i]),
			.rd_byte_b (rd_b_byte[i])
		);
	end

	// gather lane outputs back into words
	always_comb begin
		for (int i = 0; i < bram_geom_pkg::lane_count; i++) begin
			lane_rd.bytes[i] = rd_a_byte[i];
			rd_b_lanes.bytes[i] = rd_b_byte[i];
		end
	end

	assign rd_data_b = rd_b_lanes;

	// port b has no map, so its valid strobe is made here
	always_ff @(posedge clk_a_in) begin
		if (rst) begin
			valid_b_q <= 1'b0;
		end else begin
			valid_b_q <= en_b;
		end
	end

	assign rd_valid_b = valid_b_q;

endmodule

// ==== logic/ram_lane.sv ====
// one byte lane of shared storage with two ports, both on clk_a_in
// a same-byte write from both ports in one cycle stores port a's byte
// storage has no reset and is undefined until written

`timescale 1ns/1ps

module ram_lane (
	input  logic                      clk_a_in,
	input  logic                      rst,

	input  logic                      en_a,
	input  logic                      we_a,
	input  bram_port_pkg::word_addr_t addr_a,
	input  bram_port_pkg::byte_t      wr_byte_a,
	output bram_port_pkg::byte_t      rd_byte_a,

	input  logic                      en_b,
	input  logic                      we_b,
	input  bram_port_pkg::word_addr_t addr_b,
	input  bram_port_pkg::byte_t      wr_byte_b,
	output bram_port_pkg::byte_t      rd_byte_b
);

	bram_port_pkg::byte_t mem [bram_geom_pkg::word_depth];

	bram_port_pkg::byte_t rd_a_q;
	bram_port_pkg::byte_t rd_b_q;

	logic wr_a;
	logic wr_b;
	logic rd_a;
	logic rd_b;

	// a request either writes this lane or reads it, never both
	assign wr_a = en_a && we_a;
	assign wr_b = en_b && we_b;
	assign rd_a = en_a && !we_a;
	assign rd_b = en_b && !we_b;

	// port b goes first so that port a's byte lands last on a clash
	always_ff @(posedge clk_a_in) begin
		if (wr_b) begin
			mem[addr_b] <= wr_byte_b;
		end
		if (wr_a) begin
			mem[addr_a] <= wr_byte_a;
		end
	end

	// read registers sample the byte as it was before this edge,
	// so a read that meets a write from the other port returns old data
	always_ff @(posedge clk_a_in) begin
		if (rst) begin
			rd_a_q <= '0;
		end else if (rd_a) begin
			rd_a_q <= mem[addr_a];
		end
	end

	always_ff @(posedge clk_a_in) begin
		if (rst) begin
			rd_b_q <= '0;
		end else if (rd_b) begin
			rd_b_q <= mem[addr_b];
		end
	end

	// a written lane holds whatever it last read
	assign rd_byte_a = rd_a_q;
	assign rd_byte_b = rd_b_q;

endmodule

// ==== test/mixed_width_bram_asserts.sv ====
// protocol checks for mixed_width_bram, bound to every instance of it
// port names match the top level; only strobes and read data are watched

`timescale 1ns/1ps

module mixed_width_bram_asserts (
	input logic                 clk_a_in,
	input logic                 rst,
	input logic                 en_a,
	input logic                 rd_valid_a,
	input bram_port_pkg::half_t rd_data_a,
	input logic                 en_b,
	input logic                 rd_valid_b,
	input bram_port_pkg::word_t rd_data_b
);

	int unsigned fail_count = 0;

	// each request gives one valid strobe on the next cycle
	valid_a_follows_en: assert property (@(posedge clk_a_in) disable iff (rst)
		!$past(rst) |-> (rd_valid_a == $past(en_a)))
	else begin
		$error("rd_valid_a is not en_a delayed by one cycle");
		fail_count++;
	end

	valid_b_follows_en: assert property (@(posedge clk_a_in) disable iff (rst)
		!$past(rst) |-> (rd_valid_b == $past(en_b)))
	else begin
		$error("rd_valid_b is not en_b delayed by one cycle");
		fail_count++;
	end

	// strobes stay low in reset and on the first cycle out of it
	valid_low_after_reset: assert property (@(posedge clk_a_in)
		$past(rst) |-> (!rd_valid_a && !rd_valid_b))
	else begin
		$error("a valid strobe is high during or just after reset");
		fail_count++;
	end

	// read data moves only together with its valid strobe
	data_a_stable: assert property (@(posedge clk_a_in) disable iff (rst)
		!rd_valid_a |-> $stable(rd_data_a))
	else begin
		$error("rd_data_a changed without rd_valid_a");
		fail_count++;
	end

	data_b_stable: assert property (@(posedge clk_a_in) disable iff (rst)
		!rd_valid_b |-> $stable(rd_data_b))
	else begin
		$error("rd_data_b changed without rd_valid_b");
		fail_count++;
	end

endmodule

bind mixed_width_bram mixed_width_bram_asserts u_asserts (
	.clk_a_in   (clk_a_in),
	.rst        (rst),
	.en_a       (en_a),
	.rd_valid_a (rd_valid_a),
	.rd_data_a  (rd_data_a),
	.en_b       (en_b),
	.rd_valid_b (rd_valid_b),
	.rd_data_b  (rd_data_b)
);

// ==== test/tb_mixed_width_bram.sv ====
// random test of mixed_width_bram against a byte level model; one clock drives both ports
// addresses stay inside a 16 word window so that the two ports collide often
// bytes that were never written are masked out of every compare

`timescale 1ns/1ps

module tb_mixed_width_bram;

	localparam int window_words = 16;
	localparam int random_cycles = 200;
	// reset, fill, cross width reads and writes, three random phases, flush
	localparam int test_cycles = 4 + window_words + 2 * window_words + 3 * window_words
		+ 3 * random_cycles + 1;
	localparam int timeout_cycles = test_cycles + 50;

	logic                      clk_a_in;
	logic                      rst;
	logic                      en_a;
	bram_port_pkg::half_we_t   we_a;
	bram_port_pkg::half_addr_t addr_a;
	bram_port_pkg::half_t      wr_data_a;
	bram_port_pkg::half_t      rd_data_a;
	logic                      rd_valid_a;
	logic                      en_b;
	bram_port_pkg::word_we_t   we_b;
	bram_port_pkg::word_addr_t addr_b;
	bram_port_pkg::word_t      wr_data_b;
	bram_port_pkg::word_t      rd_data_b;
	logic                      rd_valid_b;

	// model storage and the expected read registers of each lane
	bram_port_pkg::byte_t model_mem [bram_geom_pkg::word_depth][bram_geom_pkg::lane_count];
	bit model_written [bram_geom_pkg::word_depth][bram_geom_pkg::lane_count];
	bram_port_pkg::byte_t reg_a [bram_geom_pkg::lane_count];
	bram_port_pkg::byte_t reg_b [bram_geom_pkg::lane_count];
	bit known_a [bram_geom_pkg::lane_count];
	bit known_b [bram_geom_pkg::lane_count];
	bit exp_valid_a;
	bit exp_valid_b;
	logic exp_sel_a;

	// request driven on the last edge, taken by the DUT on the next one
	logic                      req_en_a;
	bram_port_pkg::half_we_t   req_we_a;
	bram_port_pkg::half_addr_t req_addr_a;
	bram_port_pkg::half_t      req_data_a;
	logic                      req_en_b;
	bram_port_pkg::word_we_t   req_we_b;
	bram_port_pkg::word_addr_t req_addr_b;
	bram_port_pkg::word_t      req_data_b;

	bit [31:0] rng;
	int cycle_count = 0;

	mixed_width_bram UUT (
		.clk_a_in   (clk_a_in),
		.rst        (rst),
		.en_a       (en_a),
		.we_a       (we_a),
		.addr_a     (addr_a),
		.wr_data_a  (wr_data_a),
		.rd_data_a  (rd_data_a),
		.rd_valid_a (rd_valid_a),
		.en_b       (en_b),
		.we_b       (we_b),
		.addr_b     (addr_b),
		.wr_data_b  (wr_data_b),
		.rd_data_b  (rd_data_b),
		.rd_valid_b (rd_valid_b)
	);

	initial begin
		clk_a_in = 1'b0;
		forever #50 clk_a_in = ~clk_a_in;
	end

	task automatic fail_stop(input string why);
		$display("%s", why);
		$display("FAIL: see errors above");
		$fatal(1, "run stopped");
	endtask

	always @(posedge clk_a_in) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= timeout_cycles) begin
			fail_stop($sformatf("timeout: the run did not end within %0d cycles",
				timeout_cycles));
		end
	end

	function automatic bit [31:0] xorshift32(input bit [31:0] s);
		bit [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic bit [31:0] next_rand();
		rng = xorshift32(rng);
		return rng;
	endfunction

	task automatic check_half(input string name, input bram_port_pkg::half_t expected,
			input bram_port_pkg::half_t actual, input bram_port_pkg::half_t care);
		if ((actual & care) !== (expected & care)) begin
			fail_stop($sformatf("error %s: rd_data_a expected %h actual %h (mask %h)",
				name, expected & care, actual, care));
		end
	endtask

	task automatic check_word(input string name, input bram_port_pkg::word_t expected,
			input bram_port_pkg::word_t actual, input bram_port_pkg::word_t care);
		if ((actual & care) !== (expected & care)) begin
			fail_stop($sformatf("error %s: rd_data_b expected %h actual %h (mask %h)",
				name, expected & care, actual, care));
		end
	endtask

	task automatic check_valid(input string name, input string what, input bit expected,
			input bit actual);
		if (actual !== expected) begin
			fail_stop($sformatf("error %s: %s expected %0b actual %0b",
				name, what, expected, actual));
		end
	endtask

	task automatic reset_model();
		for (int w = 0; w < bram_geom_pkg::word_depth; w++) begin
			for (int l = 0; l < bram_geom_pkg::lane_count; l++) begin
				model_written[w][l] = 1'b0;
			end
		end
		for (int l = 0; l < bram_geom_pkg::lane_count; l++) begin
			reg_a[l] = '0;
			reg_b[l] = '0;
			known_a[l] = 1'b1;
			known_b[l] = 1'b1;
		end
		exp_valid_a = 1'b0;
		exp_valid_b = 1'b0;
		exp_sel_a = 1'b0;
		req_en_a = 1'b0;
		req_en_b = 1'b0;
	endtask

	// all reads see the storage from before the edge, then b writes, then a
	task automatic apply_model();
		bram_port_pkg::word_lanes_u ua;
		bram_port_pkg::word_lanes_u ub;
		bram_port_pkg::word_addr_t word_a;
		logic sel;
		int l;
		word_a = req_addr_a[bram_geom_pkg::half_addr_width-1:1];
		sel = req_addr_a[0];
		ua = '0;
		ua.halves[0] = req_data_a;
		ub = req_data_b;
		if (req_en_a) begin
			for (int j = 0; j < bram_geom_pkg::half_lanes; j++) begin
				l = int'(sel) * bram_geom_pkg::half_lanes + j;
				if (!req_we_a[j]) begin
					reg_a[l] = model_mem[word_a][l];
					known_a[l] = model_written[word_a][l];
				end
			end
		end
		if (req_en_b) begin
			for (int k = 0; k < bram_geom_pkg::lane_count; k++) begin
				if (!req_we_b[k]) begin
					reg_b[k] = model_mem[req_addr_b][k];
					known_b[k] = model_written[req_addr_b][k];
				end
			end
			for (int k = 0; k < bram_geom_pkg::lane_count; k++) begin
				if (req_we_b[k]) begin
					model_mem[req_addr_b][k] = ub.bytes[k];
					model_written[req_addr_b][k] = 1'b1;
				end
			end
		end
		if (req_en_a) begin
			for (int j = 0; j < bram_geom_pkg::half_lanes; j++) begin
				l = int'(sel) * bram_geom_pkg::half_lanes + j;
				if (req_we_a[j]) begin
					model_mem[word_a][l] = ua.bytes[j];
					model_written[word_a][l] = 1'b1;
				end
			end
			exp_sel_a = sel;
		end
		exp_valid_a = req_en_a;
		exp_valid_b = req_en_b;
	endtask

	task automatic check_outputs(input string name);
		bram_port_pkg::word_lanes_u exp_a;
		bram_port_pkg::word_lanes_u care_a;
		bram_port_pkg::word_lanes_u exp_b;
		bram_port_pkg::word_lanes_u care_b;
		for (int l = 0; l < bram_geom_pkg::lane_count; l++) begin
			exp_a.bytes[l] = reg_a[l];
			care_a.bytes[l] = {bram_geom_pkg::byte_width{known_a[l]}};
			exp_b.bytes[l] = reg_b[l];
			care_b.bytes[l] = {bram_geom_pkg::byte_width{known_b[l]}};
		end
		check_valid(name, "rd_valid_a", exp_valid_a, rd_valid_a);
		check_valid(name, "rd_valid_b", exp_valid_b, rd_valid_b);
		check_half(name, exp_a.halves[exp_sel_a], rd_data_a, care_a.halves[exp_sel_a]);
		check_word(name, bram_port_pkg::word_t'(exp_b), rd_data_b,
			bram_port_pkg::word_t'(care_b));
	endtask

	task automatic run_cycle(input string name,
			input logic ea, input bram_port_pkg::half_we_t wa,
			input bram_port_pkg::half_addr_t aa, input bram_port_pkg::half_t da,
			input logic eb, input bram_port_pkg::word_we_t wb,
			input bram_port_pkg::word_addr_t ab, input bram_port_pkg::word_t db);
		@(posedge clk_a_in);
		apply_model();
		en_a <= ea;
		we_a <= wa;
		addr_a <= aa;
		wr_data_a <= da;
		en_b <= eb;
		we_b <= wb;
		addr_b <= ab;
		wr_data_b <= db;
		req_en_a = ea;
		req_we_a = wa;
		req_addr_a = aa;
		req_data_a = da;
		req_en_b = eb;
		req_we_b = wb;
		req_addr_b = ab;
		req_data_b = db;
		@(negedge clk_a_in);
		check_outputs(name);
	endtask

	// same_word puts both ports on one word of the window
	task automatic random_cycle(input string name, input logic use_a, input logic use_b,
			input bit same_word);
		bit [31:0] r;
		bram_port_pkg::word_addr_t word_idx;
		bram_port_pkg::half_addr_t half_idx;
		bram_port_pkg::half_t data_a;
		bram_port_pkg::word_t data_b;
		r = next_rand();
		data_a = bram_port_pkg::half_t'(next_rand());
		data_b = next_rand();
		word_idx = bram_port_pkg::word_addr_t'(r % window_words);
		if (same_word) begin
			half_idx = {word_idx, r[4]};
		end else begin
			half_idx = bram_port_pkg::half_addr_t'(r[9:5]);
		end
		run_cycle(name, use_a, r[11:10], half_idx, data_a, use_b, r[15:12], word_idx, data_b);
	endtask

	initial begin
		bit [31:0] pick;
		rst = 1'b1;
		en_a = 1'b0;
		we_a = '0;
		addr_a = '0;
		wr_data_a = '0;
		en_b = 1'b0;
		we_b = '0;
		addr_b = '0;
		wr_data_b = '0;
		rng = 32'h96b8_a8de;
		reset_model();
		repeat (4) @(posedge clk_a_in);
		rst <= 1'b0;
		@(negedge clk_a_in);
		check_outputs("reset");

		// port b fills the window, port a reads it back as halfwords
		for (int w = 0; w < window_words; w++) begin
			run_cycle("fill_b", 1'b0, '0, '0, '0,
				1'b1, '1, bram_port_pkg::word_addr_t'(w), next_rand());
		end
		for (int h = 0; h < 2 * window_words; h++) begin
			run_cycle("b_to_a", 1'b1, '0, bram_port_pkg::half_addr_t'(h), '0,
				1'b0, '0, '0, '0);
		end
		for (int h = 0; h < 2 * window_words; h++) begin
			run_cycle("a_to_b", 1'b1, '1, bram_port_pkg::half_addr_t'(h),
				bram_port_pkg::half_t'(next_rand()), 1'b0, '0, '0, '0);
		end
		for (int w = 0; w < window_words; w++) begin
			run_cycle("a_to_b", 1'b0, '0, '0, '0,
				1'b1, '0, bram_port_pkg::word_addr_t'(w), '0);
		end

		// one port at a time with random byte enables
		for (int i = 0; i < random_cycles; i++) begin
			pick = next_rand();
			random_cycle("byte_enables", pick[0], !pick[0], 1'b0);
		end
		for (int i = 0; i < random_cycles; i++) begin
			random_cycle("back_to_back", 1'b1, 1'b1, 1'b0);
		end
		for (int i = 0; i < random_cycles; i++) begin
			random_cycle("collision", 1'b1, 1'b1, 1'b1);
		end
		run_cycle("flush", 1'b0, '0, '0, '0, 1'b0, '0, '0, '0);

		if (UUT.u_asserts.fail_count == 0) begin
			$display("PASS: all tests");
			$finish;
		end else begin
			fail_stop($sformatf("%0d concurrent assertion failures during the run",
				UUT.u_asserts.fail_count));
		end
	end

endmodule

// ==== verilog.f ====
logic/bram_geom_pkg.sv
logic/bram_port_pkg.sv
logic/ram_lane.sv
logic/half_port_map.sv
logic/mixed_width_bram.sv
test/mixed_width_bram_asserts.sv
test/tb_mixed_width_bram.sv
